// File: include/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// core sizes
`define CSR_TLB_IDX_WID 4           // 16 tlb entries
`define CSR_PALEN       32          // ppn in tlbelo ends at bit palen-5
`define CSR_ASID_WID    10
`define CSR_ADDR_WID    14

// register addresses, csr number space
`define CSR_A_CRMD      14'h000
`define CSR_A_PRMD      14'h001
`define CSR_A_EUEN      14'h002
`define CSR_A_ECFG      14'h004
`define CSR_A_ESTAT     14'h005
`define CSR_A_ERA       14'h006
`define CSR_A_BADV      14'h007
`define CSR_A_EENTRY    14'h00c
`define CSR_A_TLBIDX    14'h010
`define CSR_A_TLBEHI    14'h011
`define CSR_A_TLBELO0   14'h012
`define CSR_A_TLBELO1   14'h013
`define CSR_A_ASID      14'h018
`define CSR_A_PGDL      14'h019
`define CSR_A_PGDH      14'h01a
`define CSR_A_PGD       14'h01b     // read only view
`define CSR_A_CPUID     14'h020
`define CSR_A_SAVE0     14'h030
`define CSR_A_SAVE1     14'h031
`define CSR_A_SAVE2     14'h032
`define CSR_A_SAVE3     14'h033
`define CSR_A_TLBRENTRY 14'h088

`endif

// File: rtl/csr_pkg.sv
`include "csr_params.svh"

package csr_pkg;

    typedef logic [31:0] u32_t;
    typedef logic [`CSR_ADDR_WID-1:0] csr_addr_t;

    // csrrd / csrwr / csrxchg
    typedef enum logic [1:0] {
        CSR_RD   = 2'd0,
        CSR_WR   = 2'd1,
        CSR_XCHG = 2'd2
    } csr_op_e;

    typedef enum logic {
        TLB_OP_RD   = 1'b0,     // tlbrd result, five writes
        TLB_OP_SRCH = 1'b1      // tlbsrch result, tlbidx only
    } tlb_op_e;

    // one access on the shared register port
    typedef struct packed {
        logic      valid;
        csr_addr_t addr;
        logic      we;
        u32_t      wdata;
        u32_t      wmask;       // set bits come from wdata, others keep old value
    } csr_port_req_t;

    typedef struct packed {
        csr_op_e   op;
        csr_addr_t addr;
        u32_t      wdata;
        u32_t      wmask;       // only looked at by csrxchg
    } csr_inst_cmd_t;

    // what the tlb array hands back after tlbrd / tlbsrch
    typedef struct packed {
        tlb_op_e                     op;
        logic                        hit;
        logic [`CSR_TLB_IDX_WID-1:0] index;
        logic [5:0]                  ps;
        u32_t                        ehi;
        u32_t                        elo0;
        u32_t                        elo1;
        logic [`CSR_ASID_WID-1:0]    asid;
    } tlb_cmd_t;

    typedef struct packed {
        logic [1:0]               plv;
        logic                     da;
        logic                     pg;
        logic [`CSR_ASID_WID-1:0] asid;
        logic [19:0]              pgd_base;   // pgd[31:12]
    } mmu_ctx_t;

    typedef struct packed {
        logic [22:0] r0_1;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic [18:0] r0_1;      // ecode and esubcode, no exception entry here
        logic        is_ipi;    // no ipi
        logic        is_ti;
        logic        r0_2;
        logic [7:0]  is_hw;
        logic [1:0]  is_swi;
    } estat_t;

    typedef struct packed {
        logic                        ne;
        logic                        r0_1;
        logic [5:0]                  ps;
        logic [23:`CSR_TLB_IDX_WID]  r0_2;
        logic [`CSR_TLB_IDX_WID-1:0] index;
    } tlbidx_t;

    typedef struct packed {
        logic [31:`CSR_PALEN-4] r0_1;
        logic [`CSR_PALEN-5:8]  ppn;
        logic                   r0_2;
        logic                   g;
        logic [1:0]             mat;
        logic [1:0]             plv;
        logic                   d;
        logic                   v;
    } tlbelo_t;

    typedef struct packed {
        logic [7:0]               r0_1;
        logic [7:0]               asidbits;
        logic [15:`CSR_ASID_WID]  r0_2;
        logic [`CSR_ASID_WID-1:0] asid;
    } asid_t;

    typedef enum logic [1:0] {
        INST_IDLE,
        INST_ISSUE,
        INST_ACK,
        INST_WAIT_DROP
    } inst_state_e;

    typedef enum logic [2:0] {
        TLBW_IDLE,
        TLBW_EHI,
        TLBW_ELO0,
        TLBW_ELO1,
        TLBW_ASID,
        TLBW_IDX,
        TLBW_ACK
    } tlbw_state_e;

endpackage

// File: rtl/csr_file.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module csr_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  csr_pkg::csr_port_req_t port,
    output csr_pkg::u32_t          rd_data,
    input  logic [7:0]             int_hw,
    input  logic                   int_ti,
    output csr_pkg::mmu_ctx_t      mmu_ctx
);
    import csr_pkg::*;

    // stored state, only writable bits ever get set
    crmd_t                    crmd_q;
    u32_t                     prmd_q;
    u32_t                     euen_q;
    u32_t                     ecfg_q;
    logic [1:0]               swi_q;        // estat software interrupt bits
    u32_t                     era_q;
    u32_t                     badv_q;
    u32_t                     eentry_q;
    tlbidx_t                  tlbidx_q;
    u32_t                     tlbehi_q;
    tlbelo_t                  tlbelo_q [2];
    logic [`CSR_ASID_WID-1:0] asid_q;
    u32_t                     pgdl_q;
    u32_t                     pgdh_q;
    u32_t                     save_q [4];
    u32_t                     tlbrentry_q;

    estat_t      estat_v;
    asid_t       asid_v;
    logic [19:0] pgd_base;
    u32_t        merged;        // value after the masked write
    logic        wr_en;

    // writable bits per address
    function automatic u32_t wmask_of(csr_addr_t a);
        case (a)
            `CSR_A_CRMD:    return 32'h0000_01ff;
            `CSR_A_PRMD:    return 32'h0000_0007;
            `CSR_A_EUEN:    return 32'h0000_0001;
            `CSR_A_ECFG:    return 32'h0000_1bff;     // lie 12:11 and 9:0
            `CSR_A_ESTAT:   return 32'h0000_0003;
            `CSR_A_ERA, `CSR_A_BADV, `CSR_A_SAVE0, `CSR_A_SAVE1, `CSR_A_SAVE2, `CSR_A_SAVE3:
                return '1;
            `CSR_A_EENTRY, `CSR_A_TLBRENTRY:
                return 32'hffff_ffc0;                 // 64 byte aligned
            `CSR_A_TLBIDX:  return 32'hbf00_0000 | ((32'h1 << `CSR_TLB_IDX_WID) - 32'h1);
            `CSR_A_TLBEHI:  return 32'hffff_e000;
            `CSR_A_TLBELO0, `CSR_A_TLBELO1:
                return ((32'h1 << (`CSR_PALEN - 4)) - 32'h1) & 32'hffff_ff7f;
            `CSR_A_ASID:    return (32'h1 << `CSR_ASID_WID) - 32'h1;
            `CSR_A_PGDL, `CSR_A_PGDH:
                return 32'hffff_f000;
            default:        return '0;                // pgd, cpuid, holes
        endcase
    endfunction

    // composite views with live and constant fields
    always_comb begin
        estat_v         = '0;
        estat_v.is_swi  = swi_q;
        estat_v.is_hw   = int_hw;                     // live lines, not stored
        estat_v.is_ti   = int_ti;
        asid_v          = '0;
        asid_v.asidbits = 8'(`CSR_ASID_WID);
        asid_v.asid     = asid_q;
    end

    assign pgd_base = badv_q[31] ? pgdh_q[31:12] : pgdl_q[31:12];

    always_comb begin
        case (port.addr)
            `CSR_A_CRMD:      rd_data = crmd_q;
            `CSR_A_PRMD:      rd_data = prmd_q;
            `CSR_A_EUEN:      rd_data = euen_q;
            `CSR_A_ECFG:      rd_data = ecfg_q;
            `CSR_A_ESTAT:     rd_data = estat_v;
            `CSR_A_ERA:       rd_data = era_q;
            `CSR_A_BADV:      rd_data = badv_q;
            `CSR_A_EENTRY:    rd_data = eentry_q;
            `CSR_A_TLBIDX:    rd_data = tlbidx_q;
            `CSR_A_TLBEHI:    rd_data = tlbehi_q;
            `CSR_A_TLBELO0:   rd_data = tlbelo_q[0];
            `CSR_A_TLBELO1:   rd_data = tlbelo_q[1];
            `CSR_A_ASID:      rd_data = asid_v;
            `CSR_A_PGDL:      rd_data = pgdl_q;
            `CSR_A_PGDH:      rd_data = pgdh_q;
            `CSR_A_PGD:       rd_data = {pgd_base, 12'h000};
            `CSR_A_CPUID:     rd_data = '0;           // single core
            `CSR_A_SAVE0:     rd_data = save_q[0];
            `CSR_A_SAVE1:     rd_data = save_q[1];
            `CSR_A_SAVE2:     rd_data = save_q[2];
            `CSR_A_SAVE3:     rd_data = save_q[3];
            `CSR_A_TLBRENTRY: rd_data = tlbrentry_q;
            default:          rd_data = '0;
        endcase
    end

    assign wr_en  = port.valid & port.we;
    assign merged = ((rd_data & ~port.wmask) | (port.wdata & port.wmask)) & wmask_of(port.addr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crmd_q      <= '0;
            crmd_q.da   <= 1'b1;                      // direct address after reset
            prmd_q      <= '0;
            euen_q      <= '0;
            ecfg_q      <= '0;
            swi_q       <= '0;
            era_q       <= '0;
            badv_q      <= '0;
            eentry_q    <= '0;
            tlbidx_q    <= '0;
            tlbehi_q    <= '0;
            tlbelo_q    <= '{default: '0};
            asid_q      <= '0;
            pgdl_q      <= '0;
            pgdh_q      <= '0;
            save_q      <= '{default: '0};
            tlbrentry_q <= '0;
        end else if (wr_en) begin
            case (port.addr)
                `CSR_A_CRMD:      crmd_q      <= crmd_t'(merged);
                `CSR_A_PRMD:      prmd_q      <= merged;
                `CSR_A_EUEN:      euen_q      <= merged;
                `CSR_A_ECFG:      ecfg_q      <= merged;
                `CSR_A_ESTAT:     swi_q       <= merged[1:0];
                `CSR_A_ERA:       era_q       <= merged;
                `CSR_A_BADV:      badv_q      <= merged;
                `CSR_A_EENTRY:    eentry_q    <= merged;
                `CSR_A_TLBIDX:    tlbidx_q    <= tlbidx_t'(merged);
                `CSR_A_TLBEHI:    tlbehi_q    <= merged;
                `CSR_A_TLBELO0:   tlbelo_q[0] <= tlbelo_t'(merged);
                `CSR_A_TLBELO1:   tlbelo_q[1] <= tlbelo_t'(merged);
                `CSR_A_ASID:      asid_q      <= merged[`CSR_ASID_WID-1:0];
                `CSR_A_PGDL:      pgdl_q      <= merged;
                `CSR_A_PGDH:      pgdh_q      <= merged;
                `CSR_A_SAVE0:     save_q[0]   <= merged;
                `CSR_A_SAVE1:     save_q[1]   <= merged;
                `CSR_A_SAVE2:     save_q[2]   <= merged;
                `CSR_A_SAVE3:     save_q[3]   <= merged;
                `CSR_A_TLBRENTRY: tlbrentry_q <= merged;
                default: ;                            // pgd, cpuid and holes drop writes
            endcase
        end
    end

    // translation context for the mmu
    assign mmu_ctx.plv      = crmd_q.plv;
    assign mmu_ctx.da       = crmd_q.da;
    assign mmu_ctx.pg       = crmd_q.pg;
    assign mmu_ctx.asid     = asid_q;
    assign mmu_ctx.pgd_base = pgd_base;

    // any cpuid access leaves the whole register state as it was
    a_cpuid_no_effect: assert property (@(posedge clk) disable iff (!rst_n)
        port.valid && port.addr == `CSR_A_CPUID |=>
            $stable({crmd_q, prmd_q, euen_q, ecfg_q, swi_q, era_q, badv_q, eentry_q,
                     tlbidx_q, tlbehi_q, tlbelo_q[0], tlbelo_q[1], asid_q, pgdl_q, pgdh_q,
                     save_q[0], save_q[1], save_q[2], save_q[3], tlbrentry_q}));

endmodule

// File: rtl/csr_port_arbiter.sv
`timescale 1ns/1ps

module csr_port_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  csr_pkg::csr_port_req_t inst_port,
    input  csr_pkg::csr_port_req_t tlb_port,
    output logic                   inst_gnt,
    output logic                   tlb_gnt,
    output csr_pkg::csr_port_req_t port
);

    logic inst_turn_q;      // inst unit wins a tie when set

    // same cycle grant, a lone requester always wins
    assign inst_gnt = inst_port.valid & (inst_turn_q | ~tlb_port.valid);
    assign tlb_gnt  = tlb_port.valid & (~inst_turn_q | ~inst_port.valid);

    always_comb begin
        port = '0;          // idle port, valid low
        if (inst_gnt)
            port = inst_port;
        else if (tlb_gnt)
            port = tlb_port;
    end

    // pointer flips to the other peer after every grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            inst_turn_q <= 1'b0;                      // tlb writer first
        else if (inst_gnt)
            inst_turn_q <= 1'b0;
        else if (tlb_gnt)
            inst_turn_q <= 1'b1;
    end

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(inst_gnt && tlb_gnt));

    a_gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        (inst_gnt |-> inst_port.valid) and (tlb_gnt |-> tlb_port.valid));

endmodule

// File: rtl/csr_inst_unit.sv
`timescale 1ns/1ps

module csr_inst_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_req,
    input  csr_pkg::csr_inst_cmd_t inst_cmd,
    output logic                   inst_ack,
    output csr_pkg::u32_t          inst_rdata,
    output csr_pkg::csr_port_req_t port,
    input  logic                   gnt,
    input  csr_pkg::u32_t          port_rdata
);
    import csr_pkg::*;

    inst_state_e state_q;
    inst_state_e state_d;
    u32_t        old_q;     // register value from the grant cycle

    always_comb begin
        state_d = state_q;
        case (state_q)
            INST_IDLE:      if (inst_req) state_d = INST_ISSUE;
            INST_ISSUE:     if (gnt) state_d = INST_ACK;        // access done this cycle
            INST_ACK:       state_d = INST_WAIT_DROP;
            INST_WAIT_DROP: if (!inst_req) state_d = INST_IDLE;
            default:        state_d = INST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state_q <= INST_IDLE;
        else
            state_q <= state_d;
    end

    // command held stable by the host while req is up
    always_comb begin
        port.valid = (state_q == INST_ISSUE);
        port.addr  = inst_cmd.addr;
        port.we    = (inst_cmd.op == CSR_WR) || (inst_cmd.op == CSR_XCHG);   // csrrd reads only
        port.wdata = inst_cmd.wdata;
        port.wmask = (inst_cmd.op == CSR_XCHG) ? inst_cmd.wmask : '1;
    end

    always_ff @(posedge clk) begin
        if (state_q == INST_ISSUE && gnt)
            old_q <= port_rdata;
    end

    assign inst_rdata = old_q;
    assign inst_ack   = (state_q == INST_ACK) || (state_q == INST_WAIT_DROP);  // held until req falls

    // four phase rule on the host side
    a_ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(inst_ack) |-> !inst_req);

endmodule

// File: rtl/tlb_csr_writer.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module tlb_csr_writer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   tlb_req,
    input  csr_pkg::tlb_cmd_t      tlb_cmd,
    output logic                   tlb_ack,
    output csr_pkg::csr_port_req_t port,
    input  logic                   gnt
);
    import csr_pkg::*;

    tlbw_state_e state_q;
    tlbw_state_e state_d;
    tlb_cmd_t    cmd_q;
    tlbidx_t     idx_v;     // tlbidx image built from the result
    tlbidx_t     idx_m;     // tlbidx bits this command touches
    asid_t       asid_v;

    // tlbrd walks ehi, elo0, elo1, asid, idx and tlbsrch goes straight to idx
    always_comb begin
        state_d = state_q;
        case (state_q)
            TLBW_IDLE:
                if (tlb_req)
                    state_d = (tlb_cmd.op == TLB_OP_RD) ? TLBW_EHI : TLBW_IDX;
            TLBW_EHI:  if (gnt) state_d = TLBW_ELO0;
            TLBW_ELO0: if (gnt) state_d = TLBW_ELO1;
            TLBW_ELO1: if (gnt) state_d = TLBW_ASID;
            TLBW_ASID: if (gnt) state_d = TLBW_IDX;
            TLBW_IDX:  if (gnt) state_d = TLBW_ACK;
            TLBW_ACK:  if (!tlb_req) state_d = TLBW_IDLE;
            default:   state_d = TLBW_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state_q <= TLBW_IDLE;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk) begin
        if (state_q == TLBW_IDLE && tlb_req)
            cmd_q <= tlb_cmd;
    end

    always_comb begin
        idx_v       = '0;
        idx_v.ne    = ~cmd_q.hit;
        idx_v.ps    = cmd_q.ps;
        idx_v.index = cmd_q.index;
        idx_m       = '1;                             // tlbrd rewrites all of tlbidx
        if (cmd_q.op == TLB_OP_SRCH) begin
            idx_m       = '0;
            idx_m.ne    = 1'b1;
            idx_m.index = {`CSR_TLB_IDX_WID{cmd_q.hit}};   // miss keeps old index
        end
        asid_v      = '0;
        asid_v.asid = cmd_q.asid;
    end

    always_comb begin
        port.valid = (state_q != TLBW_IDLE) && (state_q != TLBW_ACK);
        port.we    = 1'b1;
        port.wmask = '1;
        case (state_q)
            TLBW_EHI:  {port.addr, port.wdata} = {`CSR_A_TLBEHI, cmd_q.ehi};
            TLBW_ELO0: {port.addr, port.wdata} = {`CSR_A_TLBELO0, cmd_q.elo0};
            TLBW_ELO1: {port.addr, port.wdata} = {`CSR_A_TLBELO1, cmd_q.elo1};
            TLBW_ASID: {port.addr, port.wdata} = {`CSR_A_ASID, asid_v};
            TLBW_IDX: begin
                {port.addr, port.wdata} = {`CSR_A_TLBIDX, idx_v};
                port.wmask = idx_m;
            end
            default:   {port.addr, port.wdata} = '0;
        endcase
    end

    assign tlb_ack = (state_q == TLBW_ACK);

    // a pending write may not move before the arbiter takes it
    a_hold_until_gnt: assert property (@(posedge clk) disable iff (!rst_n)
        port.valid && !gnt |=> port.valid && $stable(port));

endmodule

// File: rtl/csr_subsys_top.sv
`timescale 1ns/1ps

module csr_subsys_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_req,
    input  csr_pkg::csr_inst_cmd_t inst_cmd,
    output logic                   inst_ack,
    output csr_pkg::u32_t          inst_rdata,
    input  logic                   tlb_req,
    input  csr_pkg::tlb_cmd_t      tlb_cmd,
    output logic                   tlb_ack,
    input  logic [7:0]             int_hw,
    input  logic                   int_ti,
    output csr_pkg::mmu_ctx_t      mmu_ctx
);
    import csr_pkg::*;

    csr_port_req_t inst_port;
    csr_port_req_t tlb_port;
    csr_port_req_t arb_port;    // granted access into the register file
    logic          inst_gnt;
    logic          tlb_gnt;
    u32_t          rd_data;     // pre-write value of the granted address

    csr_inst_unit u_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_req   (inst_req),
        .inst_cmd   (inst_cmd),
        .inst_ack   (inst_ack),
        .inst_rdata (inst_rdata),
        .port       (inst_port),
        .gnt        (inst_gnt),
        .port_rdata (rd_data)
    );

    tlb_csr_writer u_tlbw (
        .clk     (clk),
        .rst_n   (rst_n),
        .tlb_req (tlb_req),
        .tlb_cmd (tlb_cmd),
        .tlb_ack (tlb_ack),
        .port    (tlb_port),
        .gnt     (tlb_gnt)
    );

    csr_port_arbiter u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_port (inst_port),
        .tlb_port  (tlb_port),
        .inst_gnt  (inst_gnt),
        .tlb_gnt   (tlb_gnt),
        .port      (arb_port)
    );

    csr_file u_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .port    (arb_port),
        .rd_data (rd_data),
        .int_hw  (int_hw),
        .int_ti  (int_ti),
        .mmu_ctx (mmu_ctx)
    );

endmodule

// File: bench/tb_csr_subsys.sv
`timescale 1ns/1ps
`include "csr_params.svh"

module tb_csr_subsys;
    import csr_pkg::*;

    localparam int        CYCLE_LIMIT = 4000;     // about five times the full test list
    localparam int        HS_LIMIT    = 64;       // cycles allowed for one ack edge
    localparam csr_addr_t UNIMPL      = 14'h3ff;  // hole in the csr map
    localparam u32_t      IDX_BITS    = (32'h1 << `CSR_TLB_IDX_WID) - 32'h1;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          inst_req;
    csr_inst_cmd_t inst_cmd;
    logic          inst_ack;
    u32_t          inst_rdata;
    logic          tlb_req;
    tlb_cmd_t      tlb_cmd;
    logic          tlb_ack;
    logic [7:0]    int_hw;
    logic          int_ti;
    mmu_ctx_t      mmu_ctx;

    int   errors    = 0;
    int   checks    = 0;
    int   cycles    = 0;
    u32_t lcg_state = 32'ha753;
    u32_t shadow [csr_addr_t];      // expected read value per implemented address

    // every register that holds state
    csr_addr_t impl_addr [20] = '{`CSR_A_CRMD, `CSR_A_PRMD, `CSR_A_EUEN, `CSR_A_ECFG,
                                  `CSR_A_ESTAT, `CSR_A_ERA, `CSR_A_BADV, `CSR_A_EENTRY,
                                  `CSR_A_TLBIDX, `CSR_A_TLBEHI, `CSR_A_TLBELO0,
                                  `CSR_A_TLBELO1, `CSR_A_ASID, `CSR_A_PGDL, `CSR_A_PGDH,
                                  `CSR_A_SAVE0, `CSR_A_SAVE1, `CSR_A_SAVE2, `CSR_A_SAVE3,
                                  `CSR_A_TLBRENTRY};

    csr_subsys_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_req   (inst_req),
        .inst_cmd   (inst_cmd),
        .inst_ack   (inst_ack),
        .inst_rdata (inst_rdata),
        .tlb_req    (tlb_req),
        .tlb_cmd    (tlb_cmd),
        .tlb_ack    (tlb_ack),
        .int_hw     (int_hw),
        .int_ti     (int_ti),
        .mmu_ctx    (mmu_ctx)
    );

    always #2 clk = ~clk;           // 4 ns period

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic u32_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // writable bits, reset value and constant read bits of one address
    function automatic void reg_model(input csr_addr_t a, output u32_t mask,
                                      output u32_t rst_val, output u32_t fixed);
        case (a)
            `CSR_A_CRMD:  mask = 32'h0000_01ff;
            `CSR_A_PRMD:  mask = 32'h0000_0007;
            `CSR_A_EUEN:  mask = 32'h0000_0001;
            `CSR_A_ECFG:  mask = 32'h0000_1bff;    // 12:11 and 9:0
            `CSR_A_ESTAT: mask = 32'h0000_0003;    // swi only
            `CSR_A_ERA, `CSR_A_BADV, `CSR_A_SAVE0, `CSR_A_SAVE1, `CSR_A_SAVE2, `CSR_A_SAVE3:
                mask = 32'hffff_ffff;
            `CSR_A_EENTRY, `CSR_A_TLBRENTRY:
                mask = 32'hffff_ffc0;
            `CSR_A_TLBIDX: mask = 32'hbf00_0000 | IDX_BITS;   // ne, ps, index
            `CSR_A_TLBEHI: mask = 32'hffff_e000;
            `CSR_A_TLBELO0, `CSR_A_TLBELO1:
                mask = 32'h0fff_ff7f;              // 27:8 and 6:0
            `CSR_A_ASID:  mask = 32'h0000_03ff;
            `CSR_A_PGDL, `CSR_A_PGDH:
                mask = 32'hffff_f000;
            default:      mask = 32'h0;
        endcase
        rst_val = 32'h0;
        fixed   = 32'h0;
        if (a == `CSR_A_CRMD)
            rst_val = 32'h0000_0008;               // da=1 plv=0
        if (a == `CSR_A_ASID)
            fixed = u32_t'(`CSR_ASID_WID) << 16;   // asidbits
    endfunction

    function automatic u32_t after_write(csr_addr_t a, u32_t old, u32_t data, u32_t wm);
        u32_t mask;
        u32_t rst_val;
        u32_t fixed;
        reg_model(a, mask, rst_val, fixed);
        return (((old & ~wm) | (data & wm)) & mask) | fixed;
    endfunction

    function automatic u32_t pgd_model();
        return shadow[`CSR_A_BADV][31] ? shadow[`CSR_A_PGDH] : shadow[`CSR_A_PGDL];
    endfunction

    function automatic mmu_ctx_t ctx_model();
        mmu_ctx_t c;
        u32_t     crmd;
        u32_t     pgd;
        crmd       = shadow[`CSR_A_CRMD];
        pgd        = pgd_model();
        c.plv      = crmd[1:0];
        c.da       = crmd[3];
        c.pg       = crmd[4];
        c.asid     = shadow[`CSR_A_ASID][`CSR_ASID_WID-1:0];
        c.pgd_base = pgd[31:12];
        return c;
    endfunction

    function automatic tlb_cmd_t make_tlb_cmd(tlb_op_e op, logic hit);
        tlb_cmd_t c;
        u32_t     r;
        r       = lcg_next();
        c.op    = op;
        c.hit   = hit;
        c.ehi   = lcg_next();
        c.elo0  = lcg_next();
        c.elo1  = lcg_next();
        c.asid  = r[`CSR_ASID_WID-1:0];
        c.ps    = r[29:24];
        c.index = r[12 +: `CSR_TLB_IDX_WID];
        return c;
    endfunction

    // register state a tlb result should leave behind
    function automatic void tlb_model(tlb_cmd_t c);
        u32_t idx;
        idx = shadow[`CSR_A_TLBIDX];
        if (c.op == TLB_OP_RD) begin
            shadow[`CSR_A_TLBEHI]  = after_write(`CSR_A_TLBEHI, '0, c.ehi, '1);
            shadow[`CSR_A_TLBELO0] = after_write(`CSR_A_TLBELO0, '0, c.elo0, '1);
            shadow[`CSR_A_TLBELO1] = after_write(`CSR_A_TLBELO1, '0, c.elo1, '1);
            shadow[`CSR_A_ASID]    = after_write(`CSR_A_ASID, '0, u32_t'(c.asid), '1);
            idx = (u32_t'(!c.hit) << 31) | (u32_t'(c.ps) << 24) | u32_t'(c.index);
        end else if (c.hit) begin
            idx = (idx & ~(32'h8000_0000 | IDX_BITS)) | u32_t'(c.index);  // hit clears ne
        end else begin
            idx = idx | 32'h8000_0000;             // miss keeps index and ps
        end
        shadow[`CSR_A_TLBIDX] = after_write(`CSR_A_TLBIDX, '0, idx, '1);
    endfunction

    task automatic check_word(input string name, input u32_t exp, input u32_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    task automatic check_ctx(input string name, input mmu_ctx_t exp, input mmu_ctx_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    // polls one ack each cycle 1 ns after the edge
    task automatic wait_ack(input bit tlb_side, input bit level);
        int n;
        n = 0;
        while (((tlb_side ? tlb_ack : inst_ack) != level) && n < HS_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if ((tlb_side ? tlb_ack : inst_ack) != level) begin
            errors++;
            $display("handshake stuck: %s ack did not go %s within %0d cycles",
                     tlb_side ? "tlb" : "inst", level ? "high" : "low", HS_LIMIT);
        end
    endtask

    task automatic do_inst(input csr_op_e op, input csr_addr_t addr, input u32_t wdata,
                           input u32_t wmask, output u32_t old);
        @(posedge clk);
        #1;
        inst_cmd = '{op: op, addr: addr, wdata: wdata, wmask: wmask};
        inst_req = 1'b1;
        wait_ack(1'b0, 1'b1);
        old      = inst_rdata;                      // valid while ack is high
        inst_req = 1'b0;
        wait_ack(1'b0, 1'b0);
    endtask

    task automatic do_tlb(input tlb_cmd_t c);
        @(posedge clk);
        #1;
        tlb_cmd = c;
        tlb_req = 1'b1;
        wait_ack(1'b1, 1'b1);
        tlb_req = 1'b0;
        wait_ack(1'b1, 1'b0);
    endtask

    task automatic read_check(input csr_addr_t a, input u32_t exp, input string name);
        u32_t v;
        do_inst(CSR_RD, a, '0, '0, v);
        check_word(name, exp, v);
    endtask

    task automatic tlb_regs_readback(input string name);
        csr_addr_t regs [5] = '{`CSR_A_TLBEHI, `CSR_A_TLBELO0, `CSR_A_TLBELO1,
                                `CSR_A_ASID, `CSR_A_TLBIDX};
        foreach (regs[i])
            read_check(regs[i], shadow[regs[i]], $sformatf("%s %03h", name, regs[i]));
    endtask

    task automatic reset_sweep();
        u32_t mask;
        u32_t rst_val;
        u32_t fixed;
        foreach (impl_addr[i]) begin
            reg_model(impl_addr[i], mask, rst_val, fixed);
            shadow[impl_addr[i]] = rst_val | fixed;
            read_check(impl_addr[i], rst_val | fixed, $sformatf("reset %03h", impl_addr[i]));
        end
        read_check(`CSR_A_PGD, 32'h0, "reset pgd");
        read_check(`CSR_A_CPUID, 32'h0, "reset cpuid");
        read_check(UNIMPL, 32'h0, "reset unimplemented");
        check_ctx("reset mmu_ctx", ctx_model(), mmu_ctx);
    endtask

    task automatic csrwr_sweep();
        u32_t d;
        u32_t old;
        foreach (impl_addr[i]) begin
            d = lcg_next();
            do_inst(CSR_WR, impl_addr[i], d, '0, old);     // mask ignored by csrwr
            check_word($sformatf("csrwr old %03h", impl_addr[i]), shadow[impl_addr[i]], old);
            shadow[impl_addr[i]] = after_write(impl_addr[i], shadow[impl_addr[i]], d, '1);
            read_check(impl_addr[i], shadow[impl_addr[i]],
                       $sformatf("csrrd after csrwr %03h", impl_addr[i]));
        end
        d = lcg_next();
        do_inst(CSR_WR, `CSR_A_CPUID, d, '0, old);
        check_word("csrwr cpuid old", 32'h0, old);
        read_check(`CSR_A_CPUID, 32'h0, "csrwr cpuid");
        do_inst(CSR_WR, `CSR_A_PGD, d, '0, old);         // read only view
        check_word("csrwr pgd old", pgd_model(), old);
        read_check(`CSR_A_PGD, pgd_model(), "csrwr pgd");
        check_ctx("mmu_ctx after csrwr", ctx_model(), mmu_ctx);
    endtask

    task automatic csrxchg_mix();
        csr_addr_t targets [2] = '{`CSR_A_SAVE0, `CSR_A_ERA};
        u32_t      d;
        u32_t      m;
        u32_t      old;
        foreach (targets[k]) begin
            repeat (2) begin
                d = lcg_next();
                m = lcg_next();
                do_inst(CSR_XCHG, targets[k], d, m, old);
                check_word($sformatf("csrxchg old %03h", targets[k]), shadow[targets[k]], old);
                shadow[targets[k]] = after_write(targets[k], shadow[targets[k]], d, m);
                read_check(targets[k], shadow[targets[k]],
                           $sformatf("csrxchg new %03h", targets[k]));
            end
        end
    endtask

    task automatic tlb_result_writes();
        tlb_cmd_t c;
        c = make_tlb_cmd(TLB_OP_RD, 1'b1);
        do_tlb(c);
        tlb_model(c);
        tlb_regs_readback("tlbrd");
        c = make_tlb_cmd(TLB_OP_SRCH, 1'b0);              // miss
        do_tlb(c);
        tlb_model(c);
        read_check(`CSR_A_TLBIDX, shadow[`CSR_A_TLBIDX], "tlbsrch miss");
        c = make_tlb_cmd(TLB_OP_SRCH, 1'b1);              // hit
        do_tlb(c);
        tlb_model(c);
        read_check(`CSR_A_TLBIDX, shadow[`CSR_A_TLBIDX], "tlbsrch hit");
        check_ctx("mmu_ctx after tlbrd", ctx_model(), mmu_ctx);
    endtask

    // both peers start in the same cycle on disjoint registers
    task automatic peer_overlap();
        tlb_cmd_t c;
        u32_t     d;
        u32_t     old;
        u32_t     prev;
        c    = make_tlb_cmd(TLB_OP_RD, 1'b0);
        d    = lcg_next();
        prev = shadow[`CSR_A_SAVE1];
        fork
            do_inst(CSR_WR, `CSR_A_SAVE1, d, '0, old);
            do_tlb(c);
        join
        check_word("overlap csrwr old", prev, old);
        shadow[`CSR_A_SAVE1] = after_write(`CSR_A_SAVE1, prev, d, '1);
        tlb_model(c);
        read_check(`CSR_A_SAVE1, shadow[`CSR_A_SAVE1], "overlap save1");
        tlb_regs_readback("overlap");
    endtask

    task automatic irq_and_pgd();
        u32_t r;
        u32_t old;
        u32_t bv;
        for (int k = 0; k < 2; k++) begin
            r = lcg_next();
            @(posedge clk);
            #1;
            int_hw = r[15:8];
            int_ti = (k == 0);
            read_check(`CSR_A_ESTAT, shadow[`CSR_A_ESTAT] | (u32_t'(int_hw) << 2)
                       | (u32_t'(int_ti) << 11), $sformatf("estat irq %0d", k));
        end
        int_hw = '0;
        int_ti = 1'b0;
        for (int k = 0; k < 2; k++) begin
            bv     = lcg_next();
            bv[31] = (k == 0);                            // pgdh first then pgdl
            do_inst(CSR_WR, `CSR_A_BADV, bv, '0, old);
            shadow[`CSR_A_BADV] = after_write(`CSR_A_BADV, shadow[`CSR_A_BADV], bv, '1);
            read_check(`CSR_A_PGD, pgd_model(), $sformatf("pgd select %0d", k));
            check_ctx($sformatf("mmu_ctx pgd %0d", k), ctx_model(), mmu_ctx);
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        inst_req = 1'b0;
        inst_cmd = '0;
        tlb_req  = 1'b0;
        tlb_cmd  = '0;
        int_hw   = '0;
        int_ti   = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_sweep();
        csrwr_sweep();
        csrxchg_mix();
        tlb_result_writes();
        peer_overlap();
        irq_and_pgd();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: files.f
+incdir+include
rtl/csr_pkg.sv
rtl/csr_file.sv
rtl/csr_port_arbiter.sv
rtl/csr_inst_unit.sv
rtl/tlb_csr_writer.sv
rtl/csr_subsys_top.sv
bench/tb_csr_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_csr_subsys \
    -f files.f -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q '^>>> PASS$' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
